// File: list.f
+incdir+rtl
rtl/pid_pkg.sv
rtl/prop_term.sv
rtl/integ_term.sv
rtl/output_preprocessor.sv
rtl/pid_channel.sv
tb/pid_assertions.sv
tb/pid_checker.sv
tb/pid_tb.sv

// File: tb/pid_tb.sv
`include "pid_config.svh"

////////////////////////////////////////////////////////////
// pid channel testbench
// table driven samples under random dac back-pressure
////////////////////////////////////////////////////////////

module pid_tb
	import pid_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int TIMEOUT_CYCLES = 200;	// limit of every wait loop
localparam int NUM_ROWS = 11;

// one step of the run
// sample = smp +/- spread
// each row sends reps samples back to back
typedef struct packed {
	int sp;		// setpoint
	int kp;
	int ki;
	int offset;	// out_offset
	int lo;		// out_min
	int hi;		// out_max
	int clear;	// pulse integ_clear before the samples
	int smp;
	int spread;
	int reps;
	int duty;	// dac_ready high percentage
} row_t;

row_t rows [NUM_ROWS] = '{
	// proportional only with ki zero
	'{0, 256, 0, 32768, 0, 65535, 1, -100, 0, 1, 100},
	'{0, 256, 0, 32768, 0, 65535, 0, 2000, 0, 1, 100},
	'{500, -1200, 0, 20000, 0, 65535, 0, 0, 3000, 24, 100},
	// integration with small steps, then restart after a clear
	'{0, 0, 10, 1000, 0, 65535, 1, -1000, 0, 20, 100},
	'{0, 0, 10, 1000, 0, 65535, 1, -1000, 0, 3, 100},
	// drive the integrator into its limit and back out
	'{0, 0, 32767, 32768, 0, 65535, 1, -131071, 0, 300, 100},
	'{0, 0, 32767, 32768, 0, 65535, 0, 131071, 0, 280, 100},
	// clamp rails of both signs
	'{0, 32767, 0, 30000, 1000, 60000, 1, -131071, 0, 2, 100},
	'{0, 32767, 0, 30000, 1000, 60000, 0, 131071, 0, 2, 100},
	// back to back samples under random back-pressure
	'{1000, 300, 7, 32768, 2000, 63000, 1, 0, 20000, 80, 35},
	'{-2000, -90, -15, 40000, 0, 65535, 0, 0, 60000, 60, 60}
};

logic		clk50;
logic		arst_n;
logic		sample_valid;
logic		sample_ready;
sample_t	sample;
sample_t	setpoint;
coef_t		kp;
coef_t		ki;
logic		integ_clear;
dac_code_t	out_offset;
dac_code_t	out_min;
dac_code_t	out_max;
logic		dac_valid;
logic		dac_ready;
dac_code_t	dac_code;

int	duty;		// current dac_ready duty
int	timeouts;
int	failures;
bit	aborted;	// set when a wait runs out
bit	ok;

pid_channel DUT (.*);

pid_checker u_check (.*);

always #20 clk50 = ~clk50;	// 40 ns period

// dac side back-pressure with a new draw every cycle
always begin
	@(posedge clk50);
	#2;
	dac_ready = ($urandom % 100) < duty;
end

////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////

function automatic int jitter(int spread);
	if (spread == 0)
		return 0;
	return int'($urandom % (2 * spread + 1)) - spread;
endfunction

// holds one sample until it is taken
task automatic send_sample(input int value, output bit taken);
	int waited;
	waited = 0;
	taken = 1'b0;
	sample = sample_t'(value);
	sample_valid = 1'b1;
	while (!taken && waited < TIMEOUT_CYCLES) begin
		@(negedge clk50);
		taken = sample_ready;	// handshake lands on the coming edge
		@(posedge clk50);
		#2;
		waited++;
	end
	sample_valid = 1'b0;
	if (!taken) begin
		timeouts++;
		$display("timeout: sample_ready stayed low for %0d cycles", TIMEOUT_CYCLES);
	end
endtask

// every accepted sample has left as a dac code
task automatic wait_empty(output bit empty);
	int waited;
	waited = 0;
	empty = 1'b0;
	while (!empty && waited < TIMEOUT_CYCLES) begin
		if (u_check.pending_count() == 0) begin
			empty = 1'b1;
		end else begin
			@(posedge clk50);
			#2;
			waited++;
		end
	end
	if (!empty) begin
		timeouts++;
		$display("timeout: pipeline did not drain within %0d cycles", TIMEOUT_CYCLES);
	end
endtask

task automatic pulse_clear();
	integ_clear = 1'b1;
	@(posedge clk50);
	#2;
	integ_clear = 1'b0;
endtask

////////////////////////////////////////////////////////////
// main sequence
////////////////////////////////////////////////////////////

initial begin
	void'($urandom(32'hb48b));
	clk50 = 1'b0;
	arst_n = 1'b0;
	sample_valid = 1'b0;
	sample = '0;
	setpoint = '0;
	kp = '0;
	ki = '0;
	integ_clear = 1'b0;
	out_offset = '0;
	out_min = '0;
	out_max = '1;
	dac_ready = 1'b0;
	duty = 100;
	timeouts = 0;
	aborted = 1'b0;

	repeat (5) @(posedge clk50);
	#2;
	arst_n = 1'b1;
	repeat (2) @(posedge clk50);	// reset state checked by u_check
	#2;

	for (int r = 0; r < NUM_ROWS; r++) begin
		duty = rows[r].duty;
		wait_empty(ok);		// config only moves while idle
		if (!ok) begin
			aborted = 1'b1;
			break;
		end
		setpoint = sample_t'(rows[r].sp);
		kp = coef_t'(rows[r].kp);
		ki = coef_t'(rows[r].ki);
		out_offset = dac_code_t'(rows[r].offset);
		out_min = dac_code_t'(rows[r].lo);
		out_max = dac_code_t'(rows[r].hi);
		if (rows[r].clear != 0)
			pulse_clear();
		for (int k = 0; k < rows[r].reps; k++) begin
			send_sample(rows[r].smp + jitter(rows[r].spread), ok);
			if (!ok) begin
				aborted = 1'b1;
				break;
			end
		end
		if (aborted)
			break;
	end

	if (!aborted)
		wait_empty(ok);
	u_check.check_drained();	// codes still owed at the end are lost

	failures = u_check.fail_count + timeouts + DUT.u_assert.violation_count;
	$display("summary: %0d codes checked, %0d mismatches, %0d failures",
		u_check.checked_count, u_check.mismatch_count, failures);
	if (u_check.mismatch_count == 0 && failures == 0) begin
		$display("TESTBENCH PASSED");
	end else begin
		$display("TESTBENCH FAILED");
	end
	$finish;
end

endmodule

// File: tb/pid_checker.sv
`include "pid_config.svh"

////////////////////////////////////////////////////////////
// reference model and scoreboard of the pid channel
// watches the DUT ports only
////////////////////////////////////////////////////////////

module pid_checker
	import pid_pkg::*;
(
	input  logic		clk50,
	input  logic		arst_n,
	input  logic		sample_valid,
	input  logic		sample_ready,
	input  sample_t		sample,
	input  sample_t		setpoint,
	input  coef_t		kp,
	input  coef_t		ki,
	input  logic		integ_clear,
	input  dac_code_t	out_offset,
	input  dac_code_t	out_min,
	input  dac_code_t	out_max,
	input  logic		dac_valid,
	input  logic		dac_ready,
	input  dac_code_t	dac_code
);

timeunit 1ns;
timeprecision 1ps;

localparam longint INTEG_LIM = (64'sd1 << 40) - 64'sd1;	// integrator rail

int		mismatch_count = 0;
int		fail_count = 0;
int		checked_count = 0;
longint		model_acc;	// integrator as the rules describe it
dac_code_t	exp_q [$];	// codes owed, oldest first

// scale, offset and clamp of the summed terms
function automatic dac_code_t expected_code(longint total, dac_code_t offset,
		dac_code_t lo, dac_code_t hi);
	longint level;
	level = (total >>> `PID_OUT_SHIFT) + longint'(offset);
	if (level > longint'(hi))
		return hi;
	if (level < longint'(lo))
		return lo;
	return dac_code_t'(level);
endfunction

function automatic int pending_count();
	return exp_q.size();
endfunction

function automatic void check_drained();
	if (exp_q.size() != 0) begin
		fail_count++;
		$display("%0d expected dac codes never arrived", exp_q.size());
	end
endfunction

////////////////////////////////////////////////////////////
// per edge model
////////////////////////////////////////////////////////////

always @(posedge clk50) begin
	dac_code_t	want;
	longint		err;
	if (!arst_n) begin
		model_acc = 0;
		exp_q.delete();
	end else begin
		// output side first
		if (dac_valid && dac_ready) begin
			if (exp_q.size() == 0) begin
				fail_count++;
				$display("dac code %h delivered with no sample outstanding", dac_code);
			end else begin
				want = exp_q.pop_front();
				checked_count++;
				if (dac_code !== want) begin
					mismatch_count++;
					$display("MISMATCH dac_code got %h expected %h", dac_code, want);
				end
			end
		end
		if (integ_clear)
			model_acc = 0;
		if (sample_valid && sample_ready) begin
			err = longint'(setpoint) - longint'(sample);
			model_acc = model_acc + longint'(ki) * err;
			if (model_acc > INTEG_LIM)
				model_acc = INTEG_LIM;
			else if (model_acc < -INTEG_LIM)
				model_acc = -INTEG_LIM;
			exp_q.push_back(expected_code(longint'(kp) * err + model_acc,
				out_offset, out_min, out_max));
		end
	end
end

// idle state right after reset release
always @(posedge arst_n) begin
	@(negedge clk50);
	if (dac_valid !== 1'b0) begin
		mismatch_count++;
		$display("MISMATCH dac_valid after reset got %h expected %h", dac_valid, 1'b0);
	end
	if (sample_ready !== 1'b1) begin
		mismatch_count++;
		$display("MISMATCH sample_ready after reset got %h expected %h", sample_ready, 1'b1);
	end
end

endmodule

// File: tb/pid_assertions.sv
`include "pid_config.svh"

////////////////////////////////////////////////////////////
// handshake and lockstep rules, bound into pid_channel
////////////////////////////////////////////////////////////

module pid_assertions
	import pid_pkg::*;
(
	input  logic		clk50,
	input  logic		arst_n,
	input  logic		dac_valid,
	input  logic		dac_ready,
	input  dac_code_t	dac_code,
	input  logic		p_valid,	// prop term held
	input  logic		i_valid		// integ term held
);

timeunit 1ns;
timeprecision 1ps;

int	violation_count = 0;

// stalled code must not move
a_code_stable: assert property (@(posedge clk50) disable iff (!arst_n)
	dac_valid && !dac_ready |=> $stable(dac_code))
	else begin
		violation_count++;
		$error("dac_code changed while dac_ready was low");
	end

// both term units fill and drain together
a_lockstep: assert property (@(posedge clk50) disable iff (!arst_n)
	p_valid == i_valid)
	else begin
		violation_count++;
		$error("term valids differ");
	end

a_reset_idle: assert property (@(posedge clk50) $rose(arst_n) |-> !dac_valid)
	else begin
		violation_count++;
		$error("dac_valid high in the first cycle after reset");
	end

endmodule

bind pid_channel pid_assertions u_assert (
	.clk50		(clk50),
	.arst_n		(arst_n),
	.dac_valid	(dac_valid),
	.dac_ready	(dac_ready),
	.dac_code	(dac_code),
	.p_valid	(p_valid),
	.i_valid	(i_valid)
);

// File: rtl/pid_channel.sv
`include "pid_config.svh"

////////////////////////////////////////////////////////////
// one pid channel, p and i only
// sample -> {prop_term, integ_term} -> output_preprocessor
////////////////////////////////////////////////////////////

module pid_channel
	import pid_pkg::*;
(
	input  logic		clk50,		// 50MHz system clock
	input  logic		arst_n,		// async reset, active low

	// error sensor samples
	input  logic		sample_valid,
	output logic		sample_ready,
	input  sample_t		sample,

	// loop config, held while samples are in flight
	input  sample_t		setpoint,
	input  coef_t		kp,
	input  coef_t		ki,
	input  logic		integ_clear,	// one cycle pulse, channel empty

	// output shaping
	input  dac_code_t	out_offset,
	input  dac_code_t	out_min,
	input  dac_code_t	out_max,

	// dac codes
	output logic		dac_valid,
	input  logic		dac_ready,
	output dac_code_t	dac_code
);

logic	p_valid;	// p term held
acc_t	p_term;
logic	i_valid;	// i term held, always equal to p_valid
acc_t	i_term;
logic	term_ready;	// drains both term units together

////////////////////////////////////////////////////////////
// term units, side by side on each sample
////////////////////////////////////////////////////////////

prop_term u_prop (
	.clk50		(clk50),
	.arst_n		(arst_n),
	.in_valid	(sample_valid),
	.in_ready	(sample_ready),	// stands for both units
	.sample		(sample),
	.setpoint	(setpoint),
	.kp		(kp),
	.out_valid	(p_valid),
	.out_ready	(term_ready),
	.term		(p_term)
);

integ_term u_integ (
	.clk50		(clk50),
	.arst_n		(arst_n),
	.in_valid	(sample_valid),
	.in_ready	(),		// same as the p unit's ready
	.sample		(sample),
	.setpoint	(setpoint),
	.ki		(ki),
	.integ_clear	(integ_clear),
	.out_valid	(i_valid),
	.out_ready	(term_ready),
	.term		(i_term)
);

////////////////////////////////////////////////////////////
// output stage
////////////////////////////////////////////////////////////

output_preprocessor u_opp (
	.clk50		(clk50),
	.arst_n		(arst_n),
	.p_valid	(p_valid),
	.p_term		(p_term),
	.i_valid	(i_valid),
	.i_term		(i_term),
	.term_ready	(term_ready),
	.out_offset	(out_offset),
	.out_min	(out_min),
	.out_max	(out_max),
	.dac_valid	(dac_valid),
	.dac_ready	(dac_ready),
	.dac_code	(dac_code)
);

endmodule

// File: rtl/output_preprocessor.sv
`include "pid_config.svh"

////////////////////////////////////////////////////////////
// output preprocessor
// joins p and i, then (p + i) >>> shift + offset, clamped
// to [out_min, out_max] and registered as the dac code
////////////////////////////////////////////////////////////

module output_preprocessor
	import pid_pkg::*;
(
	input  logic		clk50,		// 50MHz system clock
	input  logic		arst_n,		// async reset, active low

	// term inputs, drained together
	input  logic		p_valid,
	input  acc_t		p_term,
	input  logic		i_valid,
	input  acc_t		i_term,
	output logic		term_ready,

	// output shaping
	input  dac_code_t	out_offset,	// code at zero error ("init")
	input  dac_code_t	out_min,	// lower clamp
	input  dac_code_t	out_max,	// upper clamp

	// dac code out
	output logic		dac_valid,
	input  logic		dac_ready,
	output dac_code_t	dac_code
);

////////////////////////////////////////////////////////////
// join
////////////////////////////////////////////////////////////

logic	room;		// output register free or freeing
logic	take;		// pair consumed this edge

assign room = !dac_valid || dac_ready;
assign take = p_valid && i_valid && room;
assign term_ready = take;	// both units pop on the same edge

////////////////////////////////////////////////////////////
// sum, scale, offset
////////////////////////////////////////////////////////////

acc_t		sum;		// p + i, no wrap at these magnitudes
acc_t		scaled;		// sum after the right shift
acc_t		shifted;	// scaled plus offset
acc_t		lim_lo;		// out_min in the signed domain
acc_t		lim_hi;		// out_max in the signed domain
dac_code_t	clamped;

assign sum = p_term + i_term;
assign scaled = sum >>> `PID_OUT_SHIFT;	// keeps the sign

// offset and limits are straight binary codes, zero extended
assign shifted = scaled + $signed({1'b0, out_offset});
assign lim_lo = $signed({1'b0, out_min});
assign lim_hi = $signed({1'b0, out_max});

always_comb begin
	if (shifted > lim_hi) begin
		clamped = out_max;
	end else if (shifted < lim_lo) begin
		clamped = out_min;
	end else begin
		clamped = shifted[`PID_W_DAC-1:0];	// inside range, fits 16 bits
	end
end

////////////////////////////////////////////////////////////
// output register
////////////////////////////////////////////////////////////

always_ff @(posedge clk50 or negedge arst_n) begin
	if (!arst_n) begin
		dac_valid <= 1'b0;
	end else if (room) begin
		dac_valid <= p_valid && i_valid;	// load a pair or go empty
	end
end

// code holds while dac_ready is low
always_ff @(posedge clk50) begin
	if (take) begin
		dac_code <= clamped;
	end
end

endmodule

// File: rtl/integ_term.sv
`include "pid_config.svh"

////////////////////////////////////////////////////////////
// integral term unit
// acc += ki * (setpoint - sample), saturated at +/- limit
////////////////////////////////////////////////////////////

module integ_term
	import pid_pkg::*;
(
	input  logic		clk50,		// 50MHz system clock
	input  logic		arst_n,		// async reset, active low

	// sample in
	input  logic		in_valid,
	output logic		in_ready,
	input  sample_t		sample,
	input  sample_t		setpoint,
	input  coef_t		ki,		// integral gain
	input  logic		integ_clear,	// zero the accumulator

	// term out
	output logic		out_valid,
	input  logic		out_ready,
	output acc_t		term
);

////////////////////////////////////////////////////////////
// increment and saturating add
////////////////////////////////////////////////////////////

logic signed [`PID_W_SAMPLE:0]	err;		// setpoint - sample
acc_t				incr;		// ki * err
acc_t				acc;		// accumulator, doubles as the output register
acc_t				acc_base;	// starting point of this add
acc_t				acc_sum;	// raw sum before the limit
acc_t				acc_sat;	// sum after the limit
logic				accept;

assign err = setpoint - sample;
assign incr = err * ki;		// |incr| < 2^34

// a clear in the same cycle as a sample restarts from zero
// and the sample's increment is the first one added
assign acc_base = integ_clear ? '0 : acc;
assign acc_sum = acc_base + incr;	// cannot wrap, |acc| <= 2^40

always_comb begin
	if (acc_sum > acc_t'(`PID_INTEG_LIMIT)) begin
		acc_sat = acc_t'(`PID_INTEG_LIMIT);	// positive rail
	end else if (acc_sum < -acc_t'(`PID_INTEG_LIMIT)) begin
		acc_sat = -acc_t'(`PID_INTEG_LIMIT);	// negative rail
	end else begin
		acc_sat = acc_sum;
	end
end

////////////////////////////////////////////////////////////
// handshake and state
////////////////////////////////////////////////////////////

assign in_ready = !out_valid || out_ready;	// same rule as the p unit, keeps them in step
assign accept = in_valid && in_ready;

always_ff @(posedge clk50 or negedge arst_n) begin
	if (!arst_n) begin
		out_valid <= 1'b0;
	end else if (in_ready) begin
		out_valid <= in_valid;
	end
end

// accumulator is loop state, so it starts from zero
always_ff @(posedge clk50 or negedge arst_n) begin
	if (!arst_n) begin
		acc <= '0;
	end else if (accept) begin
		acc <= acc_sat;		// new value is also the term handed on
	end else if (integ_clear) begin
		acc <= '0;
	end
end

assign term = acc;	// term always shows the latest accumulator

endmodule

// File: rtl/prop_term.sv
`include "pid_config.svh"

////////////////////////////////////////////////////////////
// proportional term unit
// term = kp * (setpoint - sample), one register stage
////////////////////////////////////////////////////////////

module prop_term
	import pid_pkg::*;
(
	input  logic		clk50,		// 50MHz system clock
	input  logic		arst_n,		// async reset, active low

	// sample in
	input  logic		in_valid,
	output logic		in_ready,
	input  sample_t		sample,
	input  sample_t		setpoint,
	input  coef_t		kp,		// proportional gain

	// term out
	output logic		out_valid,
	input  logic		out_ready,
	output acc_t		term
);

////////////////////////////////////////////////////////////
// error and product
////////////////////////////////////////////////////////////

logic signed [`PID_W_SAMPLE:0]	err;	// one extra bit, difference of two samples
acc_t				product;	// kp * err at full width
logic				accept;		// sample taken this edge

assign err = setpoint - sample;	// sign extended in 19 bit context
assign product = err * kp;	// both signed, evaluated at 48 bits

////////////////////////////////////////////////////////////
// one-deep output register
////////////////////////////////////////////////////////////

// room when empty or when the held term leaves this cycle
assign in_ready = !out_valid || out_ready;
assign accept = in_valid && in_ready;

always_ff @(posedge clk50 or negedge arst_n) begin
	if (!arst_n) begin
		out_valid <= 1'b0;
	end else if (in_ready) begin
		out_valid <= in_valid;	// refill or go empty
	end
end

// payload only moves with an accepted sample
always_ff @(posedge clk50) begin
	if (accept) begin
		term <= product;
	end
end

endmodule

// File: rtl/pid_pkg.sv
`include "pid_config.svh"

////////////////////////////////////////////////////////////
// shared data types of the pid channel
////////////////////////////////////////////////////////////

package pid_pkg;

	// error sensor sample, also used for the setpoint
	typedef logic signed [`PID_W_SAMPLE-1:0] sample_t;

	// loop gain, kp and ki
	typedef logic signed [`PID_W_COEF-1:0] coef_t;

	// full width term
	// p term, i accumulator, and their sum all live here
	typedef logic signed [`PID_W_ACC-1:0] acc_t;

	// code sent to the dac, straight binary
	typedef logic [`PID_W_DAC-1:0] dac_code_t;

endpackage

// File: rtl/pid_config.svh
`ifndef PID_CONFIG_SVH
`define PID_CONFIG_SVH

////////////////////////////////////////////////////////////
// data path widths
////////////////////////////////////////////////////////////

`define PID_W_SAMPLE	18	// adc sample and setpoint width
`define PID_W_COEF	16	// kp / ki width, signed
`define PID_W_ACC	48	// computation and accumulator width
`define PID_W_DAC	16	// dac code width, unsigned

////////////////////////////////////////////////////////////
// scaling and limits
////////////////////////////////////////////////////////////

// arithmetic right shift applied to p + i before the offset
`define PID_OUT_SHIFT	8

// integrator magnitude limit, 2^40 - 1
// keeps the accumulator well inside 48 bits so the add
// of one increment can never wrap
`define PID_INTEG_LIMIT	(48'sh00FF_FFFF_FFFF)

`endif
